// ==== include/book_defs.svh ====
/* Order book price-level list sizing macros */

`ifndef BOOK_DEFS_SVH
`define BOOK_DEFS_SVH

// Number of price levels held in the list
`define BOOK_DEPTH 8

// Price key, half a word
`define BOOK_KEY_W 16

// Volume at a price level, one word
`define BOOK_VOL_W 32

// Enough bits to count 0 to BOOK_DEPTH inclusive
`define BOOK_SIZE_W 4

`endif

// ==== hdl/book_pkg.sv ====
/* Order book list types, shared by the list datapath and its control */

`include "book_defs.svh"

package book_pkg;

  // Command encoding on i_cmd
  typedef enum logic [1:0] {
    CMD_CLEAR   = 2'd0,
    CMD_ADD     = 2'd1,
    CMD_DELETE  = 2'd2,
    CMD_REPLACE = 2'd3
  } cmd_t;

  // Price key of one level
  typedef logic [`BOOK_KEY_W-1:0] key_t;

  // Volume of one level
  typedef logic [`BOOK_VOL_W-1:0] vol_t;

  // Count of valid levels
  typedef logic [`BOOK_SIZE_W-1:0] size_t;

  // One bit per level, bit 0 is the head
  typedef logic [`BOOK_DEPTH-1:0] entry_vec_t;

endpackage

// ==== hdl/book_match.sv ====
/* Parallel key compare of the command key against every stored level */

`timescale 1ns/10ps

`include "book_defs.svh"

module book_match (
    input  book_pkg::key_t       i_key
  , input  book_pkg::key_t       i_keys [`BOOK_DEPTH]
  , input  book_pkg::entry_vec_t i_vld
  // Valid levels strictly below the command key
  , output book_pkg::entry_vec_t o_cmp
  // Valid levels equal to the command key
  , output book_pkg::entry_vec_t o_match
  , output logic                 o_hit
  , output logic                 o_full
);

  // One comparator pair per level
  for (genvar i = 0; i < `BOOK_DEPTH; i++) begin : g_cmp
    // Sorted list plus packed valid gives a run of ones from bit 0
    assign o_cmp[i]   = i_vld[i] & (i_keys[i] < i_key);
    // Duplicates allowed, several bits may be set
    assign o_match[i] = i_vld[i] & (i_keys[i] == i_key);
  end

  // Any level carries the command key
  assign o_hit = |o_match;

  // Every level occupied
  assign o_full = &i_vld;

endmodule

// ==== hdl/list_ctrl.sv ====
/* Command decode and mask generation for the level list
   Holds the valid vector and raises size and head strobes */

`timescale 1ns/10ps

`include "book_defs.svh"

module list_ctrl (
    input  logic                 i_clk
  , input  logic                 i_rst
  , input  logic                 i_cmd_vld
  , input  book_pkg::cmd_t       i_cmd
  , input  book_pkg::entry_vec_t i_cmp
  , input  book_pkg::entry_vec_t i_match
  , input  logic                 i_hit
  , input  logic                 i_full
  , output book_pkg::entry_vec_t o_vld
  , output book_pkg::entry_vec_t o_take_right
  , output book_pkg::entry_vec_t o_take_left
  , output book_pkg::entry_vec_t o_ins_key
  , output book_pkg::entry_vec_t o_ins_vol
  , output logic                 o_size_inc
  , output logic                 o_size_dec
  , output logic                 o_size_clr
  , output logic                 o_head_clr
  , output logic                 o_head_add
  , output logic                 o_head_del
  , output logic                 o_head_rep
);

  localparam book_pkg::entry_vec_t LSB_ONE = book_pkg::entry_vec_t'(1);

  logic op_clr;
  logic op_add;
  logic op_del;
  logic op_rep;

  book_pkg::entry_vec_t vld_r;
  book_pkg::entry_vec_t vld_nxt;
  book_pkg::entry_vec_t add_ins;
  book_pkg::entry_vec_t add_up;
  book_pkg::entry_vec_t del_sel;
  book_pkg::entry_vec_t del_up;

  // Decode, qualified by the strobe
  assign op_clr = i_cmd_vld & (i_cmd == book_pkg::CMD_CLEAR);
  assign op_add = i_cmd_vld & (i_cmd == book_pkg::CMD_ADD);
  assign op_del = i_cmd_vld & (i_cmd == book_pkg::CMD_DELETE);
  assign op_rep = i_cmd_vld & (i_cmd == book_pkg::CMD_REPLACE);

  // Insert point is the first zero of the compare run
  // All ones means full with the largest key, so no insert
  assign add_ins = ~i_cmp & (i_cmp + LSB_ONE);
  // Insert point and every level above it
  assign add_up  = ~(add_ins - LSB_ONE);

  // Lowest matching level wins on DELETE
  assign del_sel = i_match & (~i_match + LSB_ONE);
  assign del_up  = ~(del_sel - LSB_ONE);

  // ADD moves valid levels from the insert point up one place
  // Top level falls off the end when the list is full
  assign o_take_right = {`BOOK_DEPTH{op_add}} & ((vld_r & add_up) << 1);
  // DELETE pulls every level above the removed one down
  assign o_take_left  = {`BOOK_DEPTH{op_del}} & del_up;
  assign o_ins_key    = {`BOOK_DEPTH{op_add}} & add_ins;
  // REPLACE writes every matching level
  assign o_ins_vol    = ({`BOOK_DEPTH{op_add}} & add_ins) |
                        ({`BOOK_DEPTH{op_rep}} & i_match);

  // Next valid vector
  always_comb begin
    vld_nxt = vld_r;
    if (op_clr) begin
      vld_nxt = '0;
    end else if (op_add) begin
      // Stays all ones when full
      vld_nxt = {vld_r[`BOOK_DEPTH-2:0], 1'b1};
    end else if (op_del && i_hit) begin
      vld_nxt = vld_r >> 1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      vld_r <= '0;
    end else begin
      vld_r <= vld_nxt;
    end
  end

  assign o_vld = vld_r;

  // Size strobes
  assign o_size_inc = op_add & ~i_full;
  assign o_size_dec = op_del & i_hit;
  assign o_size_clr = op_clr;

  // Head events, one-hot by construction of the decode
  assign o_head_clr = op_clr & vld_r[0];
  assign o_head_add = op_add & add_ins[0];
  assign o_head_del = op_del & i_match[0];
  assign o_head_rep = op_rep & i_match[0];

  // Valid levels always form a run from the head with no holes
  a_vld_packed : assert property (@(posedge i_clk) disable iff (i_rst)
    (vld_r & (vld_r + LSB_ONE)) == '0);

endmodule

// ==== hdl/entry_shift.sv ====
/* One register column of the level list, shared by keys and volumes */

`timescale 1ns/10ps

`include "book_defs.svh"

module entry_shift #(
  parameter type T = logic [7:0]
) (
    input  logic                 i_clk
  // Entry takes the value from the level below it
  , input  book_pkg::entry_vec_t i_take_right
  // Entry takes the value from the level above it
  , input  book_pkg::entry_vec_t i_take_left
  , input  book_pkg::entry_vec_t i_insert
  , input  T                     i_new
  , output T                     o_entries [`BOOK_DEPTH]
);

  for (genvar i = 0; i < `BOOK_DEPTH; i++) begin : g_entry
    // End levels fall back on themselves, so a shift there is a hold
    localparam int ABOVE = (i == `BOOK_DEPTH - 1) ? i : i + 1;
    localparam int BELOW = (i == 0) ? i : i - 1;

    // Payload only, validity lives in list control
    always_ff @(posedge i_clk) begin
      if (i_insert[i]) begin
        o_entries[i] <= i_new;
      end else if (i_take_left[i]) begin
        o_entries[i] <= o_entries[ABOVE];
      end else if (i_take_right[i]) begin
        o_entries[i] <= o_entries[BELOW];
      end
    end
  end

  // ADD and DELETE never overlap, so no level is pulled both ways
  a_no_dual_shift : assert property (@(posedge i_clk)
    (i_take_right & i_take_left) == '0);

endmodule

// ==== hdl/list_count.sv ====
/* Level count of the list, tracks ADD, DELETE and CLEAR */

`timescale 1ns/10ps

`include "book_defs.svh"

module list_count (
    input  logic            i_clk
  , input  logic            i_rst
  , input  logic            i_inc
  , input  logic            i_dec
  , input  logic            i_clr
  , output book_pkg::size_t o_size
);

  localparam book_pkg::size_t SIZE_ONE = book_pkg::size_t'(1);

  // Clear first, then step up or down
  always_ff @(posedge i_clk) begin
    if (i_rst || i_clr) begin
      o_size <= '0;
    end else if (i_inc) begin
      o_size <= o_size + SIZE_ONE;
    end else if (i_dec) begin
      o_size <= o_size - SIZE_ONE;
    end
  end

  // Count stays in step with the valid vector
  a_size_max : assert property (@(posedge i_clk) disable iff (i_rst)
    o_size <= `BOOK_DEPTH);
  a_no_underflow : assert property (@(posedge i_clk) disable iff (i_rst)
    i_dec |-> (o_size != '0));

endmodule

// ==== hdl/head_notify.sv ====
/* Registered head-change report, one pulse per head event */

`timescale 1ns/10ps

`include "book_defs.svh"

module head_notify (
    input  logic           i_clk
  , input  logic           i_rst
  , input  logic           i_head_clr
  , input  logic           i_head_add
  , input  logic           i_head_del
  , input  logic           i_head_rep
  // Command key and volume of this cycle
  , input  book_pkg::key_t i_key
  , input  book_pkg::vol_t i_new_vol
  // Volume held at the head before the update
  , input  book_pkg::vol_t i_head_vol
  , output logic           o_notify_vld
  , output book_pkg::key_t o_notify_key
  , output book_pkg::vol_t o_notify_volume
);

  logic           any_evt;
  book_pkg::vol_t vol_sel;

  assign any_evt = i_head_clr | i_head_add | i_head_del | i_head_rep;

  // Add and replace report the volume now at the head
  always_comb begin
    vol_sel = i_new_vol;
    if (i_head_clr) begin
      // Cleared head carries no volume
      vol_sel = '0;
    end else if (i_head_del) begin
      // Removed head reports what it held
      vol_sel = i_head_vol;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_notify_vld <= 1'b0;
    end else begin
      o_notify_vld <= any_evt;
    end
  end

  // Key and volume only move with an event
  always_ff @(posedge i_clk) begin
    if (any_evt) begin
      o_notify_key    <= i_key;
      o_notify_volume <= vol_sel;
    end
  end

  // Control decodes a single command per cycle
  a_one_event : assert property (@(posedge i_clk) disable iff (i_rst)
    $onehot0({i_head_clr, i_head_add, i_head_del, i_head_rep}));

endmodule

// ==== hdl/book_top.sv ====
/* Sorted price-level list for one book side
   Accepts one command per clock and flags every change at the head */

`timescale 1ns/10ps

`include "book_defs.svh"

module book_top (
    input  logic               i_clk
  , input  logic               i_rst
  // Command strobe and payload
  , input  logic               i_cmd_vld
  , input  book_pkg::cmd_t     i_cmd
  , input  book_pkg::key_t     i_key
  , input  book_pkg::vol_t     i_volume
  // Head change report
  , output logic               o_notify_vld
  , output book_pkg::key_t     o_notify_key
  , output book_pkg::vol_t     o_notify_volume
  // Current number of levels
  , output book_pkg::size_t    o_listsize
);

  // Registered list state
  book_pkg::key_t       keys [`BOOK_DEPTH];
  book_pkg::vol_t       vols [`BOOK_DEPTH];
  book_pkg::entry_vec_t vld;

  // Compare results against the command key
  book_pkg::entry_vec_t cmp;
  book_pkg::entry_vec_t match;
  logic                 hit;
  logic                 full;

  // Per-entry update masks
  book_pkg::entry_vec_t take_right;
  book_pkg::entry_vec_t take_left;
  book_pkg::entry_vec_t ins_key;
  book_pkg::entry_vec_t ins_vol;

  // Size and head event strobes
  logic size_inc;
  logic size_dec;
  logic size_clr;
  logic head_clr;
  logic head_add;
  logic head_del;
  logic head_rep;

  book_match u_match (
      .i_key   (i_key)
    , .i_keys  (keys)
    , .i_vld   (vld)
    , .o_cmp   (cmp)
    , .o_match (match)
    , .o_hit   (hit)
    , .o_full  (full)
  );

  list_ctrl u_ctrl (
      .i_clk        (i_clk)
    , .i_rst        (i_rst)
    , .i_cmd_vld    (i_cmd_vld)
    , .i_cmd        (i_cmd)
    , .i_cmp        (cmp)
    , .i_match      (match)
    , .i_hit        (hit)
    , .i_full       (full)
    , .o_vld        (vld)
    , .o_take_right (take_right)
    , .o_take_left  (take_left)
    , .o_ins_key    (ins_key)
    , .o_ins_vol    (ins_vol)
    , .o_size_inc   (size_inc)
    , .o_size_dec   (size_dec)
    , .o_size_clr   (size_clr)
    , .o_head_clr   (head_clr)
    , .o_head_add   (head_add)
    , .o_head_del   (head_del)
    , .o_head_rep   (head_rep)
  );

  // Key column, written on ADD only
  entry_shift #(.T(book_pkg::key_t)) u_keys (
      .i_clk        (i_clk)
    , .i_take_right (take_right)
    , .i_take_left  (take_left)
    , .i_insert     (ins_key)
    , .i_new        (i_key)
    , .o_entries    (keys)
  );

  // Volume column, written on ADD and REPLACE
  entry_shift #(.T(book_pkg::vol_t)) u_vols (
      .i_clk        (i_clk)
    , .i_take_right (take_right)
    , .i_take_left  (take_left)
    , .i_insert     (ins_vol)
    , .i_new        (i_volume)
    , .o_entries    (vols)
  );

  list_count u_count (
      .i_clk  (i_clk)
    , .i_rst  (i_rst)
    , .i_inc  (size_inc)
    , .i_dec  (size_dec)
    , .i_clr  (size_clr)
    , .o_size (o_listsize)
  );

  head_notify u_notify (
      .i_clk           (i_clk)
    , .i_rst           (i_rst)
    , .i_head_clr      (head_clr)
    , .i_head_add      (head_add)
    , .i_head_del      (head_del)
    , .i_head_rep      (head_rep)
    , .i_key           (i_key)
    , .i_new_vol       (i_volume)
    , .i_head_vol      (vols[0])
    , .o_notify_vld    (o_notify_vld)
    , .o_notify_key    (o_notify_key)
    , .o_notify_volume (o_notify_volume)
  );

endmodule

// ==== bench/book_tb.sv ====
/* Testbench for the sorted price-level list
   Replays the cases file and checks head notifies and the list size */

`timescale 1ns/10ps

`include "book_defs.svh"

module book_tb;

  localparam int    CLK_PERIOD = 4;
  localparam int    RST_CYCLES = 10;
  localparam int    MAX_CASES  = 64;
  // cmd, key, volume, notify valid, notify key, notify volume, size
  localparam int    FIELDS     = 7;
  localparam string CASES_FILE = "bench/book_cases.txt";

  logic            clk;
  logic            rst;
  logic            cmd_vld;
  book_pkg::cmd_t  cmd;
  book_pkg::key_t  key;
  book_pkg::vol_t  volume;
  logic            notify_vld;
  book_pkg::key_t  notify_key;
  book_pkg::vol_t  notify_volume;
  book_pkg::size_t listsize;

  // Flat case table with FIELDS words per case
  logic [31:0]     case_mem [MAX_CASES*FIELDS];
  int              num_cases;
  int              error_count;
  int              failed_cases;
  int              seed;
  bit              cases_loaded;
  // Size expected while the list sits idle
  book_pkg::size_t cur_size;

  book_top i_book_top (
      .i_clk           (clk)
    , .i_rst           (rst)
    , .i_cmd_vld       (cmd_vld)
    , .i_cmd           (cmd)
    , .i_key           (key)
    , .i_volume        (volume)
    , .o_notify_vld    (notify_vld)
    , .o_notify_key    (notify_key)
    , .o_notify_volume (notify_volume)
    , .o_listsize      (listsize)
  );

  initial begin
    clk = 1'b0;
  end

  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  // Nothing may change at the head while no command is given
  task automatic idle_cycles(input int count);
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      check_value("o_notify_vld", 64'(notify_vld), 64'(0));
      check_value("o_listsize", 64'(listsize), 64'(cur_size));
    end
  endtask

  task automatic run_case(input int n);
    int              base;
    int              errs_before;
    logic            exp_vld;
    book_pkg::key_t  exp_key;
    book_pkg::vol_t  exp_vol;
    book_pkg::size_t exp_size;
    base        = n * FIELDS;
    errs_before = error_count;
    exp_vld     = case_mem[base+3][0];
    exp_key     = case_mem[base+4][`BOOK_KEY_W-1:0];
    exp_vol     = case_mem[base+5][`BOOK_VOL_W-1:0];
    exp_size    = case_mem[base+6][`BOOK_SIZE_W-1:0];
    // Random gap of 0 to 3 quiet cycles
    idle_cycles($random(seed) & 3);
    // Command held for exactly one rising edge
    cmd_vld = 1'b1;
    cmd     = book_pkg::cmd_t'(case_mem[base][1:0]);
    key     = case_mem[base+1][`BOOK_KEY_W-1:0];
    volume  = case_mem[base+2][`BOOK_VOL_W-1:0];
    @(negedge clk);
    cmd_vld = 1'b0;
    // One cycle latency means the results are up by this falling edge
    check_value("o_notify_vld", 64'(notify_vld), 64'(exp_vld));
    if (exp_vld) begin
      check_value("o_notify_key", 64'(notify_key), 64'(exp_key));
      check_value("o_notify_volume", 64'(notify_volume), 64'(exp_vol));
    end
    check_value("o_listsize", 64'(listsize), 64'(exp_size));
    cur_size = exp_size;
    if (error_count == errs_before) begin
      $display("Case %0d %s key %0h: ok", n, cmd.name(), key);
    end else begin
      failed_cases++;
      $display("Case %0d %s key %0h: FAILED", n, cmd.name(), key);
    end
  endtask

  initial begin : main
    int errs_before;
    cmd_vld      = 1'b0;
    cmd          = book_pkg::CMD_CLEAR;
    key          = '0;
    volume       = '0;
    rst          = 1'b1;
    error_count  = 0;
    failed_cases = 0;
    cur_size     = '0;
    cases_loaded = 1'b0;
    seed         = 32'hca7e09e3;
    // Unread slots get a command word above 3 that marks the end
    for (int i = 0; i < MAX_CASES*FIELDS; i++) begin
      case_mem[i] = 32'hf000_0000 | i;
    end
    $readmemh(CASES_FILE, case_mem);
    num_cases = 0;
    while (num_cases < MAX_CASES && case_mem[num_cases*FIELDS][31:2] == '0) begin
      num_cases++;
    end
    if (num_cases == 0) begin
      $display("No cases could be read from %s", CASES_FILE);
      $display("Testbench failed");
      $finish;
    end else begin
      cases_loaded = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // Empty list and a quiet notify right out of reset
      errs_before = error_count;
      idle_cycles(2);
      if (error_count == errs_before) begin
        $display("Reset: ok");
      end else begin
        failed_cases++;
        $display("Reset: FAILED");
      end
      for (int n = 0; n < num_cases; n++) begin
        run_case(n);
      end
      $display("%0d cases run, %0d failed, %0d check errors",
               num_cases, failed_cases, error_count);
      if (error_count == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

  // Each case takes at most five clocks plus room for reset
  initial begin : watchdog
    wait (cases_loaded);
    #((num_cases * 5 + 20) * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock periods",
             num_cases * 5 + 20);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== bench/book_cases.txt ====
// Columns: cmd key volume notify_vld notify_key notify_volume listsize, all hex
// cmd 0 is CLEAR, 1 is ADD, 2 is DELETE, 3 is REPLACE
0 0000 00000000 0 0000 00000000 0
// Adds out of key order, head changes notify
1 0100 00000010 1 0100 00000010 1
1 0300 00000030 0 0000 00000000 2
1 0080 00000008 1 0080 00000008 3
1 0200 00000020 0 0000 00000000 4
1 0050 00000005 1 0050 00000005 5
// Delete below head, delete head, delete a missing key
2 0080 00000000 0 0000 00000000 4
2 0050 00000000 1 0050 00000005 3
2 0999 00000000 0 0000 00000000 3
// Replace head, replace below head, replace a missing key
3 0100 00000011 1 0100 00000011 3
3 0300 00000033 0 0000 00000000 3
3 0777 00000077 0 0000 00000000 3
// Fill the list
1 0400 00000040 0 0000 00000000 4
1 0500 00000050 0 0000 00000000 5
1 0600 00000060 0 0000 00000000 6
1 0700 00000070 0 0000 00000000 7
1 0090 90000009 1 0090 90000009 8
// Full list, top key ignored, others push the top out
1 0800 00000080 0 0000 00000000 8
1 0250 00000025 0 0000 00000000 8
1 0010 00000001 1 0010 00000001 8
2 0010 00000000 1 0010 00000001 7
2 0090 00000000 1 0090 90000009 6
2 0600 00000000 0 0000 00000000 6
2 0700 00000000 0 0000 00000000 6
// Clear a full list, then an empty one
0 0abc 00000000 1 0abc 00000000 0
0 0000 00000000 0 0000 00000000 0
2 0100 00000000 0 0000 00000000 0
// Duplicate keys
1 0200 000000aa 1 0200 000000aa 1
1 0200 000000bb 1 0200 000000bb 2
1 0300 00000003 0 0000 00000000 3
2 0200 00000000 1 0200 000000bb 2
2 0200 00000000 1 0200 000000aa 1
1 0100 00000001 1 0100 00000001 2
1 0100 00000002 1 0100 00000002 3
3 0100 00000077 1 0100 00000077 3
2 0100 00000000 1 0100 00000077 2
2 0100 00000000 1 0100 00000077 1
2 0300 00000000 1 0300 00000003 0
0 0000 00000000 0 0000 00000000 0

// ==== files.f ====
+incdir+include
hdl/book_pkg.sv
hdl/book_match.sv
hdl/list_ctrl.sv
hdl/entry_shift.sv
hdl/list_count.sv
hdl/head_notify.sv
hdl/book_top.sv
bench/book_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the order book list

VERILATOR  ?= verilator
TOP        := book_tb
FILE_LIST  := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# Exit status follows the pass line in the run output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
